// File: fw_regfile.f
src/fw_regfile_pkg.sv
src/fw_gpr_store.sv
src/fw_csr_counters.sv
src/fw_csr_control.sv
src/fw_regfile.sv
bench/fw_regfile_tb.sv

// File: Makefile
# Verilator flow for the register file block

RTL = src/fw_regfile_pkg.sv src/fw_gpr_store.sv src/fw_csr_counters.sv \
	src/fw_csr_control.sv src/fw_regfile.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module fw_regfile $(RTL)

sim:
	verilator --binary --timing --top-module fw_regfile_tb \
		-f fw_regfile.f -o fw_regfile_sim
	./obj_dir/fw_regfile_sim | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/fw_regfile_tb.sv
// Testbench for the register file block
// Applies a table of writes, events and reads, one row per cycle, and
// checks read data, control outputs and the soft-reset strobe

`timescale 1ns/1ps

module fw_regfile_tb import fw_regfile_pkg::*; ();

	// One table row with stimulus and the values expected from it
	typedef struct packed {
		rd_write_t  wr;
		trap_evt_t  evt;
		reg_addr_t  ra;
		reg_addr_t  rb;
		logic [1:0] chk;
		word_t      exp_ra;
		word_t      exp_rb;
		int         csel;
		word_t      exp_c;
		logic       srr;
	} row_t;

	logic      clock;
	logic      reset;
	rd_write_t wr;
	trap_evt_t evt;
	reg_addr_t ra_raddr;
	reg_addr_t rb_raddr;
	word_t     ra_rdata;
	word_t     rb_rdata;
	csr_ctrl_t ctrl;
	logic      soft_reset_req;

	row_t rows [$];
	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;
	int   cycle_limit;
	int   row_idx;

	fw_regfile dut0 (
		.clock          (clock),
		.reset          (reset),
		.wr             (wr),
		.evt            (evt),
		.ra_raddr       (ra_raddr),
		.rb_raddr       (rb_raddr),
		.ra_rdata       (ra_rdata),
		.rb_rdata       (rb_rdata),
		.ctrl           (ctrl),
		.soft_reset_req (soft_reset_req)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Run limit counted in clock edges
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] row %0d %s: got 0x%h expected 0x%h", row_idx, name, got, exp);
		end
	endtask

	// chk bit 1 enables the ra check and bit 0 the rb check
	// csel picks the ctrl field as 1 mtvec, 2 dep_lo, 3 dep_hi or 4 {meie, mie}
	task automatic add_row(input logic wen, input reg_addr_t waddr, input word_t wdata,
		input logic [3:0] ev, input reg_addr_t ra, input reg_addr_t rb,
		input logic [1:0] chk, input word_t exp_ra, input word_t exp_rb,
		input int csel, input word_t exp_c, input logic srr);
		row_t r;
		r.wr     = '{wen, waddr, wdata};
		r.evt    = ev;
		r.ra     = ra;
		r.rb     = rb;
		r.chk    = chk;
		r.exp_ra = exp_ra;
		r.exp_rb = exp_rb;
		r.csel   = csel;
		r.exp_c  = exp_c;
		r.srr    = srr;
		rows.push_back(r);
	endtask

	// Registered results of row i are sampled just after the edge that took it
	task automatic check_results(input int i);
		row_idx = i;
		if (rows[i].chk[1]) check_value("ra_rdata", ra_rdata, rows[i].exp_ra);
		if (rows[i].chk[0]) check_value("rb_rdata", rb_rdata, rows[i].exp_rb);
		case (rows[i].csel)
			1: check_value("ctrl.mtvec", ctrl.mtvec, rows[i].exp_c);
			2: check_value("ctrl.dep_lo", ctrl.dep_lo, rows[i].exp_c);
			3: check_value("ctrl.dep_hi", ctrl.dep_hi, rows[i].exp_c);
			4: check_value("ctrl.meie_mie", {30'b0, ctrl.meie, ctrl.mie}, rows[i].exp_c);
			default: ;
		endcase
	endtask

	initial begin
		// Event nibble is {trap, tret, instr_complete, irq}
		// GPRs, r0 and a same-edge read, plus the reset values of ctrl
		add_row(1'b1, 6'h05, 'h1105, 4'h0, 6'h00, 6'h00, 2'b11, 'h0, 'h0, 4, 'h3, 1'b0);
		add_row(1'b1, 6'h06, 'h2206, 4'h0, 6'h05, 6'h05, 2'b11, 'h1105, 'h1105, 1, 'h0, 1'b0);
		add_row(1'b1, 6'h00, 'hbeef, 4'h0, 6'h06, 6'h06, 2'b11, 'h2206, 'h2206, 2, 'h0, 1'b0);
		add_row(1'b1, 6'h05, 'h5555, 4'h0, 6'h00, 6'h05, 2'b11, 'h0, 'h1105, 3, 'h0, 1'b0);
		add_row(1'b1, 6'h1f, 'h3131, 4'h0, 6'h05, 6'h00, 2'b11, 'h5555, 'h0, 0, 'h0, 1'b0);
		// mcycle returns the written value and then one count per edge
		add_row(1'b1, 6'h20, 'h1000, 4'h0, 6'h1f, 6'h06, 2'b11, 'h3131, 'h2206, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h20, 6'h20, 2'b11, 'h0, 'h1000, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h00, 6'h20, 2'b01, 'h0, 'h1001, 0, 'h0, 1'b0);
		add_row(1'b1, 6'h21, 'hab, 4'h0, 6'h00, 6'h21, 2'b01, 'h0, 'h0, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h00, 6'h21, 2'b01, 'h0, 'hab, 0, 'h0, 1'b0);
		// Low half kept across the mcycleh write
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h00, 6'h20, 2'b01, 'h0, 'h1003, 0, 'h0, 1'b0);
		// minstret counts only with instr_complete
		add_row(1'b1, 6'h22, 'h10, 4'h0, 6'h00, 6'h22, 2'b01, 'h0, 'h0, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h2, 6'h00, 6'h22, 2'b01, 'h0, 'h10, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h00, 6'h22, 2'b01, 'h0, 'h11, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h2, 6'h00, 6'h22, 2'b01, 'h0, 'h11, 0, 'h0, 1'b0);
		// Half write beats the increment
		add_row(1'b1, 6'h23, 'h5, 4'h2, 6'h00, 6'h22, 2'b01, 'h0, 'h12, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h22, 6'h23, 2'b11, 'h0, 'h5, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h00, 6'h22, 2'b01, 'h0, 'h12, 0, 'h0, 1'b0);
		// mip follows irq while the store slot stays clear
		add_row(1'b1, 6'h24, 'hffffffff, 4'h1, 6'h24, 6'h24, 2'b11, 'h0, 'h800, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h24, 6'h24, 2'b11, 'h0, 'h0, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h1, 6'h00, 6'h24, 2'b01, 'h0, 'h800, 0, 'h0, 1'b0);
		// Enable stack through a trap, two trets and an mstatus write
		add_row(1'b0, 6'h00, 'h0, 4'h8, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 4, 'h2, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h4, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 4, 'h3, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h4, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 4, 'h2, 1'b0);
		add_row(1'b1, 6'h28, 'h88, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 4, 'h3, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h8, 6'h00, 6'h28, 2'b01, 'h0, 'h88, 4, 'h2, 1'b0);
		// tret wins over a same-edge mstatus write
		add_row(1'b1, 6'h28, 'h0, 4'h4, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 4, 'h3, 1'b0);
		// mstatus loads mpie on its own and the next tret moves it into mie
		add_row(1'b1, 6'h28, 'h80, 4'h0, 6'h00, 6'h28, 2'b01, 'h0, 'h0, 4, 'h2, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h4, 6'h00, 6'h28, 2'b01, 'h0, 'h80, 4, 'h3, 1'b0);
		// mie register write clears and then sets meie
		add_row(1'b1, 6'h29, 'h0, 4'h0, 6'h00, 6'h28, 2'b01, 'h0, 'h80, 4, 'h1, 1'b0);
		add_row(1'b1, 6'h29, 'h800, 4'h0, 6'h00, 6'h29, 2'b01, 'h0, 'h0, 4, 'h3, 1'b0);
		// DEP bounds lock on bit 1 while the store still takes the word
		add_row(1'b1, 6'h2b, 'h100, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 2, 'h100, 1'b0);
		add_row(1'b1, 6'h2b, 'h202, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 2, 'h202, 1'b0);
		add_row(1'b1, 6'h2b, 'h300, 4'h0, 6'h00, 6'h2b, 2'b01, 'h0, 'h202, 2, 'h202, 1'b0);
		add_row(1'b1, 6'h2c, 'h400, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 3, 'h400, 1'b0);
		add_row(1'b1, 6'h2c, 'h502, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 3, 'h502, 1'b0);
		add_row(1'b1, 6'h2c, 'h600, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 3, 'h502, 1'b0);
		add_row(1'b1, 6'h2a, 'h100, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 1, 'h100, 1'b0);
		add_row(1'b1, 6'h2a, 'h200, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 1, 'h200, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 2, 'h202, 1'b0);
		// Soft-reset strobe only with an actual write
		add_row(1'b1, 6'h2d, 'h1, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 3, 'h502, 1'b1);
		add_row(1'b0, 6'h2d, 'h1, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 0, 'h0, 1'b0);
		add_row(1'b1, 6'h07, 'h77, 4'h0, 6'h00, 6'h00, 2'b00, 'h0, 'h0, 0, 'h0, 1'b0);
		add_row(1'b0, 6'h00, 'h0, 4'h0, 6'h07, 6'h00, 2'b10, 'h77, 'h0, 0, 'h0, 1'b0);

		cycle_limit = 8 + rows.size() + 20;
		reset    = 1'b1;
		wr       = '0;
		evt      = '0;
		ra_raddr = '0;
		rb_raddr = '0;
		repeat (8) @(posedge clock);
		#2 reset = 1'b0;

		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clock);
			#1;
			if (i > 0) check_results(i - 1);
			#1;
			wr       = rows[i].wr;
			evt      = rows[i].evt;
			ra_raddr = rows[i].ra;
			rb_raddr = rows[i].rb;
			// Strobe is combinational and checked within the row's own cycle
			#1;
			row_idx = i;
			check_value("soft_reset_req", {31'b0, soft_reset_req}, {31'b0, rows[i].srr});
		end
		@(posedge clock);
		#1;
		check_results(rows.size() - 1);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: src/fw_regfile.sv
// Architectural state block of the RV32 machine-mode core
// Joins the GPR/CSR store, the counters and the control CSRs, and
// merges live counters and mip into the port-B read path

`timescale 1ns/1ps

module fw_regfile import fw_regfile_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  rd_write_t wr,
	input  trap_evt_t evt,
	input  reg_addr_t ra_raddr,
	input  reg_addr_t rb_raddr,
	output word_t     ra_rdata,
	output word_t     rb_rdata,
	output csr_ctrl_t ctrl,
	output logic      soft_reset_req
);

	word_t     rb_word;
	reg_addr_t rb_addr_q;
	count_t    cycle_count;
	count_t    instr_count;
	word_t     mip_word;
	word_t     ro_snap_d;
	word_t     ro_snap_q;

	fw_gpr_store u_store (
		.clock     (clock),
		.reset     (reset),
		.wr        (wr),
		.ra_raddr  (ra_raddr),
		.rb_raddr  (rb_raddr),
		.ra_rdata  (ra_rdata),
		.rb_word   (rb_word),
		.rb_addr_q (rb_addr_q)
	);

	fw_csr_counters u_counters (
		.clock          (clock),
		.reset          (reset),
		.wr             (wr),
		.instr_complete (evt.instr_complete),
		.cycle_count    (cycle_count),
		.instr_count    (instr_count)
	);

	fw_csr_control u_control (
		.clock          (clock),
		.reset          (reset),
		.wr             (wr),
		.trap           (evt.trap),
		.tret           (evt.tret),
		.ctrl           (ctrl),
		.soft_reset_req (soft_reset_req)
	);

	// Pending word carries only the external irq level
	always_comb begin
		mip_word = '0;
		mip_word[MIP_MEIP_BIT] = evt.irq;
	end

	// Read-only window value picked by the live port-B address
	always_comb begin
		case (rb_raddr)
			ADDR_MCYCLE:    ro_snap_d = cycle_count[31:0];
			ADDR_MCYCLEH:   ro_snap_d = cycle_count[63:32];
			ADDR_MINSTRET:  ro_snap_d = instr_count[31:0];
			ADDR_MINSTRETH: ro_snap_d = instr_count[63:32];
			ADDR_MIP:       ro_snap_d = mip_word;
			default:        ro_snap_d = '0;
		endcase
	end

	// One-cycle snapshot, aligned with the store's port-B register
	always_ff @(posedge clock) begin
		ro_snap_q <= ro_snap_d;
	end

	// Window addresses come from the snapshot, all others from the store
	assign rb_rdata = (rb_addr_q[5:3] == RO_WINDOW_TAG) ? ro_snap_q : rb_word;

endmodule

// File: src/fw_csr_control.sv
// Machine control CSRs
// mtvec, DEP bounds with write lock, the mie/mpie enable stack and the
// soft-reset request strobe

`timescale 1ns/1ps

module fw_csr_control import fw_regfile_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  rd_write_t wr,
	input  logic      trap,
	input  logic      tret,
	output csr_ctrl_t ctrl,
	output logic      soft_reset_req
);

	csr_ctrl_t ctrl_q;
	logic      mpie;

	logic wr_mtvec;
	logic wr_mie;
	logic wr_mstatus;
	logic wr_dep_lo;
	logic wr_dep_hi;

	// Address decode
	assign wr_mtvec   = wr.wen && (wr.waddr == ADDR_MTVEC);
	assign wr_mie     = wr.wen && (wr.waddr == ADDR_MIE);
	assign wr_mstatus = wr.wen && (wr.waddr == ADDR_MSTATUS);

	// A bound freezes once its lock bit has been written as one
	assign wr_dep_lo = wr.wen && (wr.waddr == ADDR_DEP_LO)
		&& !ctrl_q.dep_lo[DEP_LOCK_BIT];
	assign wr_dep_hi = wr.wen && (wr.waddr == ADDR_DEP_HI)
		&& !ctrl_q.dep_hi[DEP_LOCK_BIT];

	// Strobe follows the write request, no register
	assign soft_reset_req = wr.wen && (wr.waddr == ADDR_SOFT_RESET);

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl_q.mtvec  <= RESET_MTVEC;
			ctrl_q.dep_lo <= RESET_DEP;
			ctrl_q.dep_hi <= RESET_DEP;
			ctrl_q.meie   <= RESET_MEIE;
			ctrl_q.mie    <= RESET_MIE;
			mpie          <= RESET_MPIE;
		end else begin
			if (wr_mtvec) begin
				ctrl_q.mtvec <= wr.wdata;
			end
			if (wr_dep_lo) begin
				ctrl_q.dep_lo <= wr.wdata;
			end
			if (wr_dep_hi) begin
				ctrl_q.dep_hi <= wr.wdata;
			end
			if (wr_mie) begin
				ctrl_q.meie <= wr.wdata[MIE_MEIE_BIT];
			end
			if (wr_mstatus) begin
				ctrl_q.mie <= wr.wdata[MSTATUS_MIE_BIT];
				mpie       <= wr.wdata[MSTATUS_MPIE_BIT];
			end

			// Trap entry pushes the enable stack
			// Placed after the mstatus write so it takes priority
			if (trap) begin
				mpie       <= ctrl_q.mie;
				ctrl_q.mie <= 1'b0;
			end

			// Trap return pops it
			if (tret) begin
				ctrl_q.mie <= mpie;
				mpie       <= 1'b0;
			end
		end
	end

	assign ctrl = ctrl_q;

endmodule

// File: src/fw_csr_counters.sv
// Machine counters
// 64-bit cycle and retired-instruction counters, each half writable

`timescale 1ns/1ps

module fw_csr_counters import fw_regfile_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  rd_write_t wr,
	input  logic      instr_complete,
	output count_t    cycle_count,
	output count_t    instr_count
);

	logic wr_cycle_lo;
	logic wr_cycle_hi;
	logic wr_instr_lo;
	logic wr_instr_hi;

	// Half-word write decode
	assign wr_cycle_lo = wr.wen && (wr.waddr == ADDR_MCYCLE);
	assign wr_cycle_hi = wr.wen && (wr.waddr == ADDR_MCYCLEH);
	assign wr_instr_lo = wr.wen && (wr.waddr == ADDR_MINSTRET);
	assign wr_instr_hi = wr.wen && (wr.waddr == ADDR_MINSTRETH);

	// Cycle counter
	// A half write wins over the increment and keeps the other half
	always_ff @(posedge clock) begin
		if (reset) begin
			cycle_count <= '0;
		end else if (wr_cycle_lo) begin
			cycle_count <= {cycle_count[63:32], wr.wdata};
		end else if (wr_cycle_hi) begin
			cycle_count <= {wr.wdata, cycle_count[31:0]};
		end else begin
			cycle_count <= cycle_count + count_t'(1);
		end
	end

	// Retired-instruction counter
	// Same write rules, counts only completed instructions
	always_ff @(posedge clock) begin
		if (reset) begin
			instr_count <= '0;
		end else if (wr_instr_lo) begin
			instr_count <= {instr_count[63:32], wr.wdata};
		end else if (wr_instr_hi) begin
			instr_count <= {wr.wdata, instr_count[31:0]};
		end else if (instr_complete) begin
			instr_count <= instr_count + count_t'(1);
		end
	end

endmodule

// File: src/fw_gpr_store.sv
// GPR and CSR backing store
// 64 words with gated writes and two registered read ports

`timescale 1ns/1ps

module fw_gpr_store import fw_regfile_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  rd_write_t wr,
	input  reg_addr_t ra_raddr,
	input  reg_addr_t rb_raddr,
	output word_t     ra_rdata,
	output word_t     rb_word,
	output reg_addr_t rb_addr_q
);

	word_t mem [REG_COUNT];
	logic  wr_allowed;

	// r0 is hardwired and the counter window is never shadowed
	assign wr_allowed = wr.wen
		&& (wr.waddr != '0)
		&& (wr.waddr[5:3] != RO_WINDOW_TAG);

	// Storage, fully cleared by reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_allowed) begin
			mem[wr.waddr] <= wr.wdata;
		end
	end

	// Read ports
	// Nonblocking read gives the old word on a same-edge write
	always_ff @(posedge clock) begin
		ra_rdata <= mem[ra_raddr];
		rb_word  <= mem[rb_raddr];
	end

	// Port B address kept for the CSR select in the top
	always_ff @(posedge clock) begin
		if (reset) begin
			rb_addr_q <= '0;
		end else begin
			rb_addr_q <= rb_raddr;
		end
	end

endmodule

// File: src/fw_regfile_pkg.sv
// Register file package
// Widths, CSR address map, reset values and the structs shared across
// the architectural state block

package fw_regfile_pkg;

	// Meaningful widths
	typedef logic [31:0] word_t;
	typedef logic [5:0]  reg_addr_t;
	typedef logic [63:0] count_t;

	// Store depth covers GPRs plus CSR slots
	localparam int REG_COUNT = 64;

	// Counter slots, inside the read-only window
	localparam reg_addr_t ADDR_MCYCLE     = 6'h20;
	localparam reg_addr_t ADDR_MCYCLEH    = 6'h21;
	localparam reg_addr_t ADDR_MINSTRET   = 6'h22;
	localparam reg_addr_t ADDR_MINSTRETH  = 6'h23;
	localparam reg_addr_t ADDR_MIP        = 6'h24;

	// Control CSRs
	localparam reg_addr_t ADDR_MSTATUS    = 6'h28;
	localparam reg_addr_t ADDR_MIE        = 6'h29;
	localparam reg_addr_t ADDR_MTVEC      = 6'h2A;
	localparam reg_addr_t ADDR_DEP_LO     = 6'h2B;
	localparam reg_addr_t ADDR_DEP_HI     = 6'h2C;
	localparam reg_addr_t ADDR_SOFT_RESET = 6'h2D;

	// Bit positions inside CSR words
	localparam int MSTATUS_MIE_BIT  = 3;
	localparam int MSTATUS_MPIE_BIT = 7;
	localparam int MIE_MEIE_BIT     = 11;
	localparam int MIP_MEIP_BIT     = 11;
	localparam int DEP_LOCK_BIT     = 1;

	// Upper address bits of the read-only window 0x20..0x27
	localparam logic [2:0] RO_WINDOW_TAG = 3'b100;

	// Reset values of the control state
	localparam word_t RESET_MTVEC = 32'h0000_0000;
	localparam word_t RESET_DEP   = 32'h0000_0000;
	localparam logic  RESET_MEIE  = 1'b1;
	localparam logic  RESET_MIE   = 1'b1;
	localparam logic  RESET_MPIE  = 1'b0;

	// Write request from the core
	typedef struct packed {
		logic      wen;
		reg_addr_t waddr;
		word_t     wdata;
	} rd_write_t;

	// Control outputs seen by the core
	typedef struct packed {
		word_t mtvec;
		word_t dep_lo;
		word_t dep_hi;
		logic  meie;
		logic  mie;
	} csr_ctrl_t;

	// Event strobes and the interrupt level
	typedef struct packed {
		logic trap;
		logic tret;
		logic instr_complete;
		logic irq;
	} trap_evt_t;

endpackage
